/* files.f */
hw/cart_pkg.sv
hw/cart_bus_if.sv
hw/cart_header_capture.sv
hw/mbc_bank_regs.sv
hw/cart_bus_decode.sv
hw/cram_store.sv
hw/cart_top.sv
verification/cart_sva.sv
verification/tb_cart_top.sv

/* hw/cart_bus_decode.sv */
// cartridge bus decode: rom and ram address mapping, download path and cpu read mux
`timescale 1ns/1ps

module cart_bus_decode (
	input  logic                   rom_dl,
	input  logic                   dl_wr,
	input  cart_pkg::rom_waddr_t   dl_addr,
	input  cart_pkg::rom_word_t    dl_data,
	cart_bus_if.decode             bus,
	input  cart_pkg::cart_info_t   info,
	input  cart_pkg::bank_state_t  banks,
	input  cart_pkg::rom_word_t    rom_rdata,
	input  cart_pkg::cart_byte_t   cram_q,
	output cart_pkg::rom_waddr_t   rom_addr,
	output logic                   rom_we,
	output cart_pkg::rom_word_t    rom_wdata,
	output cart_pkg::cram_addr_t   cram_addr,
	output logic                   cram_we,
	output cart_pkg::cart_byte_t   cart_do
);

	cart_pkg::rom_bank_t   eff_bank;   // effective bank for 4000-7fff
	cart_pkg::rom_bank_t   cpu_bank;   // bank for the current cpu address
	cart_pkg::ram_bank_t   ram_sel;    // ram bank before masking
	cart_pkg::cart_byte_t  ram_byte;
	logic                  in_cram;

	assign in_cram = (bus.addr[15:13] == cart_pkg::cram_window);

	// --------------------------------------------------
	// rom banking
	// --------------------------------------------------
	always_comb begin
		case (info.mbc)
			// mode 0: ram bank bits drive rom bank 6..5
			cart_pkg::mbc1: eff_bank = banks.mbc1_mode ?
				{4'b0000, banks.rom_bank[4:0]} :
				{2'b00, banks.ram_bank[1:0], banks.rom_bank[4:0]};
			cart_pkg::mbc2,
			cart_pkg::mbc3: eff_bank = {2'b00, banks.rom_bank[6:0]};
			cart_pkg::mbc5: eff_bank = banks.rom_bank;
			default:        eff_bank = {8'd0, bus.addr[14]};   // flat 32 KB
		endcase

		if (bus.addr[15:14] == 2'b01)
			cpu_bank = eff_bank & info.rom_mask;   // mirror small roms
		else
			cpu_bank = 9'd0;                       // fixed bank 0
	end

	// download addresses are bytes, the rom store takes words
	assign rom_addr  = rom_dl ? {1'b0, dl_addr[23:1]} :
		{2'b00, cpu_bank, bus.addr[13:1]};
	assign rom_we    = rom_dl && dl_wr;
	assign rom_wdata = rom_dl ? dl_data : 16'h0000;

	// --------------------------------------------------
	// ram banking
	// --------------------------------------------------
	always_comb begin
		case (info.mbc)
			cart_pkg::mbc1: ram_sel = banks.mbc1_mode ? banks.ram_bank : 4'd0;
			cart_pkg::mbc3,
			cart_pkg::mbc5: ram_sel = banks.ram_bank;
			default:        ram_sel = 4'd0;   // no mapper or mbc2 internal ram
		endcase
	end

	assign cram_addr = {ram_sel & info.ram_mask, bus.addr[12:0]};
	assign cram_we   = bus.wr && in_cram && banks.ram_enable;   // store adds the ce

	// --------------------------------------------------
	// cpu read data
	// --------------------------------------------------
	always_comb begin
		if (!banks.ram_enable)
			ram_byte = 8'hFF;                          // disabled ram floats high
		else if (banks.rtc_mode)
			ram_byte = 8'h00;                          // rtc registers not there
		else if (info.mbc == cart_pkg::mbc2 && bus.addr[15:9] == 7'b1010000)
			ram_byte = {4'hF, cram_q[3:0]};            // 512 x 4 bit ram
		else
			ram_byte = cram_q;

		if (!info.loaded)
			cart_do = 8'h00;
		else if (bus.rd && in_cram)
			cart_do = ram_byte;
		else
			cart_do = bus.addr[0] ? rom_rdata[15:8] : rom_rdata[7:0];
	end

endmodule

/* hw/cart_bus_if.sv */
// cartridge bus interface: cpu address, strobes, write data and cpu clock enable
`timescale 1ns/1ps

interface cart_bus_if;

	logic                  ce;     // cpu clock enable
	cart_pkg::cart_addr_t  addr;   // cpu cartridge address
	logic                  rd;     // cpu read strobe
	logic                  wr;     // cpu write strobe
	cart_pkg::cart_byte_t  di;     // data from cpu to cart

	// bank registers take full writes
	modport regs (
		input ce,
		input addr,
		input wr,
		input di
	);

	// address mapping and read mux
	modport decode (
		input addr,
		input rd,
		input wr
	);

	// ram array only needs the enable and write data
	modport store (
		input ce,
		input di
	);

endinterface

/* hw/cart_header_capture.sv */
// cartridge header capture: latches header bytes during rom download and decodes them
`timescale 1ns/1ps

module cart_header_capture (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic [7:0]             dl_index,
	input  logic                   dl_wr,
	input  cart_pkg::rom_waddr_t   dl_addr,
	input  cart_pkg::rom_word_t    dl_data,
	output logic                   rom_dl,
	output cart_pkg::cart_info_t   info
);

	logic [7:0] cgb_byte;     // header 0x143
	logic [7:0] type_byte;    // header 0x147
	logic [7:0] rom_size;     // header 0x148
	logic [7:0] ram_size;     // header 0x149
	logic       loaded;

	// only rom images count, other download kinds pass by
	assign rom_dl = dl_active && (dl_index == cart_pkg::idx_rom_a ||
		dl_index == cart_pkg::idx_rom_b);

	// --------------------------------------------------
	// header capture
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cgb_byte  <= 8'h00;
			type_byte <= 8'h00;
			rom_size  <= 8'h00;
			ram_size  <= 8'h00;
			loaded    <= 1'b0;
		end else if (rom_dl && dl_wr) begin
			loaded <= 1'b1;   // first image word marks the cart present
			case (dl_addr)
				cart_pkg::hdr_cgb_offset:  cgb_byte  <= dl_data[15:8];
				cart_pkg::hdr_type_offset: type_byte <= dl_data[15:8];
				cart_pkg::hdr_size_offset: begin
					rom_size <= dl_data[7:0];
					ram_size <= dl_data[15:8];
				end
				default: ;
			endcase
		end
	end

	// --------------------------------------------------
	// decode
	// --------------------------------------------------
	always_comb begin
		// controller kind from cart type byte (decimal ranges)
		if (type_byte >= 8'd1 && type_byte <= 8'd3)
			info.mbc = cart_pkg::mbc1;
		else if (type_byte == 8'd5 || type_byte == 8'd6)
			info.mbc = cart_pkg::mbc2;
		else if (type_byte >= 8'd15 && type_byte <= 8'd19)
			info.mbc = cart_pkg::mbc3;
		else if (type_byte >= 8'd25 && type_byte <= 8'd30)
			info.mbc = cart_pkg::mbc5;
		else
			info.mbc = cart_pkg::none;

		// 2^(n+1) banks for codes 0..8, odd sizes fall back to 128 banks
		if (rom_size <= 8'd8)
			info.rom_mask = 9'((10'd2 << rom_size[3:0]) - 10'd1);
		else
			info.rom_mask = 9'd127;

		if (ram_size <= 8'd2)
			info.ram_mask = 4'd0;    // none, 2 KB or a single 8 KB bank
		else if (ram_size == 8'd3)
			info.ram_mask = 4'd3;    // 32 KB, 4 banks
		else
			info.ram_mask = 4'd15;   // 128 KB, 16 banks

		info.cgb_game = (cgb_byte == 8'h80) || (cgb_byte == 8'hC0);
		info.loaded   = loaded;
	end

endmodule

/* hw/cart_pkg.sv */
// cartridge package: bus types, header offsets, download codes and region codes
package cart_pkg;

	// --------------------------------------------------
	// basic bus and memory types
	// --------------------------------------------------
	typedef logic [15:0] cart_addr_t;   // cpu side cartridge address
	typedef logic [7:0]  cart_byte_t;   // cpu data byte
	typedef logic [15:0] rom_word_t;    // rom store word
	typedef logic [23:0] rom_waddr_t;   // rom store word address
	typedef logic [16:0] cram_addr_t;   // byte address into cart ram, 16 x 8 KB
	typedef logic [8:0]  rom_bank_t;    // 16 KB rom bank, up to 512 banks
	typedef logic [3:0]  ram_bank_t;    // 8 KB ram bank, up to 16 banks

	// memory bank controller kinds we handle
	typedef enum logic [2:0] {
		none = 3'd0,    // plain 32 KB rom, no mapper
		mbc1 = 3'd1,
		mbc2 = 3'd2,
		mbc3 = 3'd3,    // rtc registers not modelled
		mbc5 = 3'd4
	} mbc_kind_e;

	// decoded cartridge header
	typedef struct packed {
		mbc_kind_e mbc;
		rom_bank_t rom_mask;   // mirrors the rom bank number by rom size
		ram_bank_t ram_mask;   // same for the ram bank
		logic      cgb_game;   // colour title
		logic      loaded;     // a rom image has been seen
	} cart_info_t;

	// cpu written bank registers
	typedef struct packed {
		rom_bank_t rom_bank;
		ram_bank_t ram_bank;
		logic      ram_enable;
		logic      mbc1_mode;  // 0: 16/8 mode, 1: 4/32 mode
		logic      rtc_mode;   // mbc3 rtc selected in the a000 window
	} bank_state_t;

	// --------------------------------------------------
	// download stream
	// --------------------------------------------------
	// byte addresses of the header words, high byte of a word is the odd address
	localparam rom_waddr_t hdr_cgb_offset  = 24'h000142;  // cgb flag at 0x143
	localparam rom_waddr_t hdr_type_offset = 24'h000146;  // cart type at 0x147
	localparam rom_waddr_t hdr_size_offset = 24'h000148;  // rom size 0x148, ram size 0x149

	localparam logic [7:0] idx_rom_a = 8'h01;   // .gb image
	localparam logic [7:0] idx_rom_b = 8'h80;   // .gbc image

	localparam logic [3:0] ram_enable_key = 4'hA;

	// --------------------------------------------------
	// cpu address regions, address bits 15..13
	// --------------------------------------------------
	typedef enum logic [2:0] {
		ram_enable  = 3'b000,   // 0000-1fff write: ram enable
		rom_bank    = 3'b001,   // 2000-3fff write: rom bank
		ram_bank    = 3'b010,   // 4000-5fff write: ram bank / rtc select
		mode_sel    = 3'b011,   // 6000-7fff write: mbc1 banking mode
		cram_window = 3'b101    // a000-bfff: cartridge ram
	} cart_region_e;

endpackage

/* hw/cart_top.sv */
// cartridge top: header capture, bank registers, bus decode and cart ram
`timescale 1ns/1ps

module cart_top #(
	parameter int cram_addr_bits = 17   // up to 128 KB of cart ram
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	// download stream
	input  logic                   dl_active,
	input  logic [7:0]             dl_index,
	input  logic                   dl_wr,
	input  cart_pkg::rom_waddr_t   dl_addr,
	input  cart_pkg::rom_word_t    dl_data,
	// cpu side
	input  logic                   cpu_ce,
	input  cart_pkg::cart_addr_t   cart_addr,
	input  logic                   cart_rd,
	input  logic                   cart_wr,
	input  cart_pkg::cart_byte_t   cart_di,
	output cart_pkg::cart_byte_t   cart_do,
	// external rom store
	input  cart_pkg::rom_word_t    rom_rdata,
	output cart_pkg::rom_waddr_t   rom_addr,
	output logic                   rom_we,
	output cart_pkg::rom_word_t    rom_wdata,
	output logic                   cgb_game
);

	logic                   rom_dl;     // rom image download in progress
	cart_pkg::cart_info_t   info;
	cart_pkg::bank_state_t  banks;
	cart_pkg::cram_addr_t   cram_addr;
	logic                   cram_we;
	cart_pkg::cart_byte_t   cram_q;

	// --------------------------------------------------
	// cpu bus bundle
	// --------------------------------------------------
	cart_bus_if bus ();

	assign bus.ce   = cpu_ce;
	assign bus.addr = cart_addr;
	assign bus.rd   = cart_rd;
	assign bus.wr   = cart_wr;
	assign bus.di   = cart_di;

	assign cgb_game = info.cgb_game;

	// --------------------------------------------------
	// blocks
	// --------------------------------------------------
	cart_header_capture u_header (
		.clk_sys(clk_sys), .reset(reset), .dl_active(dl_active), .dl_index(dl_index),
		.dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data), .rom_dl(rom_dl), .info(info)
	);

	mbc_bank_regs u_regs (
		.clk_sys(clk_sys), .reset(reset), .rom_dl(rom_dl), .bus(bus.regs), .info(info),
		.banks(banks)
	);

	cart_bus_decode u_decode (
		.rom_dl(rom_dl), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.bus(bus.decode), .info(info), .banks(banks), .rom_rdata(rom_rdata),
		.cram_q(cram_q), .rom_addr(rom_addr), .rom_we(rom_we), .rom_wdata(rom_wdata),
		.cram_addr(cram_addr), .cram_we(cram_we), .cart_do(cart_do)
	);

	cram_store #(.cram_addr_bits(cram_addr_bits)) u_cram (
		.clk_sys(clk_sys), .bus(bus.store), .cram_addr(cram_addr), .cram_we(cram_we),
		.cram_q(cram_q)
	);

endmodule

/* hw/cram_store.sv */
// cartridge ram store: byte array with cpu writes and a registered read
`timescale 1ns/1ps

module cram_store #(
	parameter int cram_addr_bits = 17    // 16 banks of 8 KB
) (
	input  logic                       clk_sys,
	cart_bus_if.store                  bus,
	input  logic [cram_addr_bits-1:0]  cram_addr,
	input  logic                       cram_we,
	output cart_pkg::cart_byte_t       cram_q
);

	localparam int depth = 1 << cram_addr_bits;

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	cart_pkg::cart_byte_t mem [depth];   // contents survive reset like battery ram

	// write on the cpu enable only
	always_ff @(posedge clk_sys) begin
		if (cram_we && bus.ce)
			mem[cram_addr] <= bus.di;
	end

	// read every edge, one cycle behind the address
	always_ff @(posedge clk_sys) begin
		cram_q <= mem[cram_addr];
	end

endmodule

/* hw/mbc_bank_regs.sv */
// mbc bank registers: cpu written rom/ram bank, banking mode and ram enable
`timescale 1ns/1ps

module mbc_bank_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   rom_dl,
	cart_bus_if.regs               bus,
	input  cart_pkg::cart_info_t   info,
	output cart_pkg::bank_state_t  banks
);

	cart_pkg::rom_bank_t     rom_bank_q;
	cart_pkg::ram_bank_t     ram_bank_q;
	logic                    ram_en_q;
	logic                    mode_q;      // mbc1 banking mode
	logic                    rtc_q;       // mbc3 rtc window select
	cart_pkg::cart_region_e  region;

	assign region = cart_pkg::cart_region_e'(bus.addr[15:13]);

	// --------------------------------------------------
	// register writes, one per cpu enable
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		// a new rom image restarts the mapper too
		if (reset || rom_dl) begin
			rom_bank_q <= 9'd1;
			ram_bank_q <= 4'd0;
			ram_en_q   <= 1'b0;
			mode_q     <= 1'b0;
			rtc_q      <= 1'b0;
		end else if (bus.ce && bus.wr) begin
			case (region)
				cart_pkg::ram_enable: begin
					ram_en_q <= (bus.di[3:0] == cart_pkg::ram_enable_key);
				end

				cart_pkg::rom_bank: begin
					if (info.mbc == cart_pkg::mbc5) begin
						if (bus.addr[12])
							rom_bank_q[8] <= bus.di[0];       // 3000-3fff high bit
						else
							rom_bank_q[7:0] <= bus.di;        // 2000-2fff low byte
					end else if (bus.di[6:0] == 7'd0) begin
						rom_bank_q <= 9'd1;                   // bank 0 maps to 1 on mbc1-3
					end else begin
						rom_bank_q <= {2'b00, bus.di[6:0]};
					end
				end

				cart_pkg::ram_bank: begin
					if (info.mbc == cart_pkg::mbc3) begin
						if (bus.di[3]) begin
							rtc_q <= 1'b1;                    // 08-0c select an rtc register
						end else begin
							rtc_q      <= 1'b0;
							ram_bank_q <= {2'b00, bus.di[1:0]};
						end
					end else if (info.mbc == cart_pkg::mbc5) begin
						ram_bank_q <= bus.di[3:0];
					end else begin
						// mbc1 keeps these two bits for rom bank 5..6 as well
						ram_bank_q <= {2'b00, bus.di[1:0]};
					end
				end

				cart_pkg::mode_sel: begin
					if (info.mbc == cart_pkg::mbc1)
						mode_q <= bus.di[0];
				end

				default: ;   // cram window writes go to the ram array
			endcase
		end
	end

	// --------------------------------------------------
	// state out
	// --------------------------------------------------
	always_comb begin
		banks.rom_bank   = rom_bank_q;
		banks.ram_bank   = ram_bank_q;
		banks.ram_enable = ram_en_q;
		banks.mbc1_mode  = mode_q;
		banks.rtc_mode   = rtc_q;
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the cartridge testbench with verilator, run it and scan the log

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f files.f --top-module tb_cart_top -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$log_file"; then
	exit 0
else
	echo "pass line not found in $log_file"
	exit 1
fi

/* verification/cart_sva.sv */
// cartridge assertions: rom store write gating and the read value before a cart is loaded
`timescale 1ns/1ps

module cart_sva (
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  rom_dl,
	input logic                  rom_we,
	input cart_pkg::cart_info_t  info,
	input cart_pkg::cart_byte_t  cart_do
);

	// --------------------------------------------------
	// download path
	// --------------------------------------------------
	// the rom store is only written by an image download
	rom_we_only_in_download: assert property (
		@(posedge clk_sys) disable iff (reset) rom_we |-> rom_dl
	) else $error("rom_we asserted while no rom image is downloading");

	// --------------------------------------------------
	// cpu read side
	// --------------------------------------------------
	// empty slot reads as zero everywhere
	unloaded_reads_zero: assert property (
		@(posedge clk_sys) disable iff (reset) !info.loaded |-> (cart_do == 8'h00)
	) else $error("cart_do not zero while no cartridge is loaded");

endmodule

bind cart_top cart_sva u_sva (
	.clk_sys(clk_sys), .reset(reset), .rom_dl(rom_dl), .rom_we(rom_we),
	.info(info), .cart_do(cart_do)
);

/* verification/tb_cart_top.sv */
// cartridge testbench: directed download, banking, cart ram and header flag tests
`timescale 1ns/1ps

module tb_cart_top;

	localparam int image_words = 256;    // covers the header words at 0x142..0x149
	localparam int max_cycles  = 20000;  // 10 image loads of ~260 cycles plus cpu accesses

	logic clk_sys = 1'b0;
	logic reset, dl_active, dl_wr, cpu_ce, cart_rd, cart_wr, rom_we, cgb_game;
	logic [7:0] dl_index;
	cart_pkg::rom_waddr_t dl_addr, rom_addr;
	cart_pkg::rom_word_t  dl_data, rom_rdata, rom_wdata;
	cart_pkg::cart_addr_t cart_addr;
	cart_pkg::cart_byte_t cart_di, cart_do;

	cart_pkg::rom_word_t rom_mem [image_words];   // rom store model, low words only
	cart_pkg::rom_word_t image [image_words];     // what the last load sent
	logic [31:0] lcg_state = 32'h3846_2d40;
	int cycles = 0;

	cart_top #(.cram_addr_bits(17)) dut (.*);

	always #2 clk_sys = ~clk_sys;   // 4 ns period

	// --------------------------------------------------
	// rom store model and helpers
	// --------------------------------------------------
	function automatic cart_pkg::rom_word_t fill_word(input cart_pkg::rom_waddr_t a);
		return a[15:0] ^ a[23:8] ^ 16'hA5C3;   // words above the image, whole address
	endfunction

	function automatic cart_pkg::rom_word_t exp_word(input cart_pkg::rom_waddr_t a);
		return (a[23:8] == 16'h0000) ? image[a[7:0]] : fill_word(a);
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	assign rom_rdata = (rom_addr[23:8] == 16'h0000) ? rom_mem[rom_addr[7:0]] :
		fill_word(rom_addr);

	always @(posedge clk_sys) begin
		if (rom_we && rom_addr[23:8] == 16'h0000)
			rom_mem[rom_addr[7:0]] <= rom_wdata;
	end

	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			stop_run();
		end
	end

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic check_byte(input string name, input cart_pkg::cart_byte_t got, exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_word(input string name, input cart_pkg::rom_word_t got, exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input cart_pkg::rom_waddr_t got, exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	// --------------------------------------------------
	// bus tasks
	// --------------------------------------------------
	// full image download with the header bytes patched in
	task automatic load_image(input logic [7:0] kind, rom_code, ram_code, cgb);
		cart_pkg::rom_word_t w;
		for (int i = 0; i < image_words; i++) begin
			w = cart_pkg::rom_word_t'(lcg_next() >> 8);
			if (i == 32'(cart_pkg::hdr_cgb_offset >> 1)) w[15:8] = cgb;
			if (i == 32'(cart_pkg::hdr_type_offset >> 1)) w[15:8] = kind;
			if (i == 32'(cart_pkg::hdr_size_offset >> 1)) w = {ram_code, rom_code};
			image[i] = w;
			@(posedge clk_sys);
			dl_active <= 1'b1;
			dl_index  <= cgb[7] ? cart_pkg::idx_rom_b : cart_pkg::idx_rom_a;
			dl_wr     <= 1'b1;
			dl_addr   <= cart_pkg::rom_waddr_t'(i * 2);   // byte address
			dl_data   <= w;
			@(negedge clk_sys);
			check_flag("rom_we", rom_we, 1'b1);
			check_word("rom_wdata", rom_wdata, w);
			check_addr("rom_addr", rom_addr, cart_pkg::rom_waddr_t'(i));
		end
		@(posedge clk_sys);
		dl_wr     <= 1'b0;
		dl_active <= 1'b0;
		@(negedge clk_sys);
		check_flag("rom_we", rom_we, 1'b0);
	endtask

	task automatic cpu_write(input cart_pkg::cart_addr_t a, input cart_pkg::cart_byte_t d);
		@(posedge clk_sys);
		cart_addr <= a;
		cart_di   <= d;
		cart_wr   <= 1'b1;
		cart_rd   <= 1'b0;
		@(posedge clk_sys);   // write edge
		cart_wr   <= 1'b0;
	endtask

	// ram window data settles by the second edge, rom reads earlier
	task automatic cpu_read(input cart_pkg::cart_addr_t a, output cart_pkg::cart_byte_t d);
		@(posedge clk_sys);
		cart_addr <= a;
		cart_rd   <= 1'b1;
		cart_wr   <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		d = cart_do;
	endtask

	// rom read with the bank the mapper should select
	task automatic check_rom_read(input cart_pkg::cart_addr_t a, input cart_pkg::rom_bank_t bank);
		cart_pkg::cart_byte_t d;
		cart_pkg::rom_waddr_t wa;
		cart_pkg::rom_word_t  w;
		cpu_read(a, d);
		// 16 KB bank is 8192 words, word offset from the byte address
		wa = cart_pkg::rom_waddr_t'(bank) * 24'd8192 + cart_pkg::rom_waddr_t'(a[13:1]);
		w  = exp_word(wa);
		check_addr("rom_addr", rom_addr, wa);
		check_byte("cart_do", d, a[0] ? w[15:8] : w[7:0]);   // odd address is the high byte
	endtask

	task automatic check_ram_read(input cart_pkg::cart_addr_t a, input cart_pkg::cart_byte_t exp);
		cart_pkg::cart_byte_t d;
		cpu_read(a, d);
		check_byte("cart_do", d, exp);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic no_cart_test();
		check_flag("rom_we", rom_we, 1'b0);
		check_ram_read(16'h0000, 8'h00);
		check_ram_read(16'h4321, 8'h00);
		check_ram_read(16'hA000, 8'h00);
		load_image(8'h00, 8'h00, 8'h00, 8'h00);   // no mapper, 32 KB
		check_rom_read(16'h0000, 9'd0);
		check_rom_read(16'h0143, 9'd0);
		check_rom_read(16'h01FF, 9'd0);
		check_rom_read(16'h4002, 9'd1);           // bank from address bit 14
	endtask

	task automatic mbc1_test();
		load_image(8'h01, 8'h06, 8'h00, 8'h00);   // 128 banks
		cpu_write(16'h2000, 8'h00);
		check_rom_read(16'h4000, 9'd1);           // zero maps to bank 1
		cpu_write(16'h2000, 8'h05);
		cpu_write(16'h4000, 8'h02);
		check_rom_read(16'h5ABD, 9'h045);         // mode 0 adds ram bank bits
		cpu_write(16'h6000, 8'h01);
		check_rom_read(16'h7001, 9'h005);         // mode 1 drops them
		load_image(8'h01, 8'h02, 8'h00, 8'h00);   // 8 banks
		cpu_write(16'h2000, 8'h1E);
		check_rom_read(16'h6FFE, 9'h006);         // 30 wraps to 6
		cpu_write(16'h4000, 8'h03);
		check_rom_read(16'h4011, 9'h006);
	endtask

	task automatic mbc5_test();
		load_image(8'h19, 8'h08, 8'h00, 8'h00);   // 512 banks
		cpu_write(16'h2000, 8'h34);
		cpu_write(16'h3000, 8'h01);
		check_rom_read(16'h4567, 9'h134);
		cpu_write(16'h2000, 8'hFF);
		check_rom_read(16'h7FFF, 9'h1FF);
		cpu_write(16'h2000, 8'h00);
		cpu_write(16'h3000, 8'h00);
		check_rom_read(16'h4001, 9'h000);         // bank 0 stays 0 on mbc5
	endtask

	task automatic cram_test();
		cart_pkg::cart_byte_t b0, b1, b5;
		b0 = cart_pkg::cart_byte_t'(lcg_next() >> 24);
		b1 = b0 ^ 8'h5A;                          // neighbour byte never equal to b0
		b5 = ~b0;                                 // other bank differs in every bit
		load_image(8'h1B, 8'h00, 8'h04, 8'h00);   // mbc5, 16 ram banks
		check_ram_read(16'hA010, 8'hFF);          // disabled after load
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h4000, 8'h00);
		cpu_write(16'hA010, b0);
		cpu_write(16'hA011, b1);
		cpu_write(16'h4000, 8'h05);
		cpu_write(16'hA010, b5);
		check_ram_read(16'hA010, b5);
		cpu_write(16'h4000, 8'h00);
		check_ram_read(16'hA010, b0);
		check_ram_read(16'hA011, b1);
		cpu_write(16'h0000, 8'h00);
		check_ram_read(16'hA010, 8'hFF);          // non key disables again
	endtask

	task automatic read_mask_test();
		load_image(8'h05, 8'h00, 8'h00, 8'h00);   // mbc2
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'hA005, 8'h3C);
		check_ram_read(16'hA005, 8'hFC);          // upper nibble reads as ones
		load_image(8'h13, 8'h00, 8'h03, 8'h00);   // mbc3, 4 ram banks
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h4000, 8'h01);
		cpu_write(16'hA100, 8'h5A);
		check_ram_read(16'hA100, 8'h5A);
		cpu_write(16'h4000, 8'h08);
		check_ram_read(16'hA100, 8'h00);          // rtc select reads zero
		cpu_write(16'h4000, 8'h01);
		check_ram_read(16'hA100, 8'h5A);
	endtask

	task automatic cgb_test();
		load_image(8'h00, 8'h00, 8'h00, 8'h80);
		@(negedge clk_sys);
		check_flag("cgb_game", cgb_game, 1'b1);
		load_image(8'h00, 8'h00, 8'h00, 8'hC0);
		@(negedge clk_sys);
		check_flag("cgb_game", cgb_game, 1'b1);
		load_image(8'h00, 8'h00, 8'h00, 8'h00);
		@(negedge clk_sys);
		check_flag("cgb_game", cgb_game, 1'b0);
	endtask

	initial begin
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_index  = 8'h00;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		cpu_ce    = 1'b1;   // full speed cpu
		cart_addr = '0;
		cart_rd   = 1'b0;
		cart_wr   = 1'b0;
		cart_di   = '0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		no_cart_test();
		mbc1_test();
		mbc5_test();
		cram_test();
		read_mask_test();
		cgb_test();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
